/* hw/dbg_cause_tracker.sv */
// Debug cause tracker
// Predicts the dcsr cause the core should report on its next debug entry

`timescale 1ns/100ps

module dbg_cause_tracker (
  input  logic                       cov_assert_if,
  input  logic                       rst_n_i,
  input  dbg_mon_pkg::ctrl_state_e   ctrl_state_i,
  input  dbg_mon_pkg::instr_class_e  instr_class_i,
  input  logic                       trigger_match_i,
  input  logic                       debug_req_i,
  input  logic                       dcsr_ebreakm_i,
  input  logic                       dcsr_step_i,
  input  logic                       is_decoding_i,
  input  logic                       instr_valid_i,
  output dbg_mon_pkg::dbg_cause_e    expected_cause_o
);

  dbg_mon_pkg::dbg_cause_e cause_q;
  dbg_mon_pkg::dbg_cause_e cause_d;

  logic is_any_ebreak;
  logic decode_valid;

  assign is_any_ebreak = (instr_class_i == dbg_mon_pkg::INSTR_EBREAK) ||
                         (instr_class_i == dbg_mon_pkg::INSTR_CEBREAK);

  assign decode_valid  = is_decoding_i & instr_valid_i;

  // ------------------------------------------------------------
  // Priority rule
  // ------------------------------------------------------------
  always_comb begin
    cause_d = cause_q;
    case (ctrl_state_i)
      dbg_mon_pkg::DECODE: begin
        // Causes are only sampled with a valid instruction in decode
        if (decode_valid) begin
          if (trigger_match_i) begin
            cause_d = dbg_mon_pkg::DBG_CAUSE_TRIGGER;
          end else if (dcsr_ebreakm_i && is_any_ebreak) begin
            cause_d = dbg_mon_pkg::DBG_CAUSE_EBREAK;
          end else if (debug_req_i) begin
            cause_d = dbg_mon_pkg::DBG_CAUSE_HALTREQ;
          end else if (dcsr_step_i) begin
            cause_d = dbg_mon_pkg::DBG_CAUSE_STEP;
          end else begin
            cause_d = dbg_mon_pkg::DBG_CAUSE_NONE;
          end
        end
      end
      dbg_mon_pkg::DBG_TAKEN_IF: begin
        // Debug taken from fetch, only haltreq or step can apply
        if (debug_req_i) begin
          cause_d = dbg_mon_pkg::DBG_CAUSE_HALTREQ;
        end else if (dcsr_step_i) begin
          cause_d = dbg_mon_pkg::DBG_CAUSE_STEP;
        end
      end
      default: begin
        cause_d = cause_q;
      end
    endcase
  end

  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      cause_q <= dbg_mon_pkg::DBG_CAUSE_NONE;
    end else begin
      cause_q <= cause_d;
    end
  end

  assign expected_cause_o = cause_q;

endmodule

/* hw/dbg_instr_classify.sv */
// Decode-stage instruction classifier
// Flags ebreak, c.ebreak, wfi and dret for the debug monitor blocks

`timescale 1ns/100ps

module dbg_instr_classify (
  input  logic                              instr_valid_i,
  input  logic                              is_decoding_i,
  input  logic                              is_compressed_i,
  input  logic [dbg_mon_pkg::INSTR_W-1:0]   instr_rdata_i,
  output dbg_mon_pkg::instr_class_e         instr_class_o
);

  // Only a valid instruction that is really being decoded counts
  logic decode_ok;

  logic hit_ebreak;
  logic hit_wfi;
  logic hit_dret;

  assign decode_ok = instr_valid_i & is_decoding_i;

  // ------------------------------------------------------------
  // Encoding matches
  // ------------------------------------------------------------
  assign hit_ebreak = (instr_rdata_i == dbg_mon_pkg::EBREAK_ENC);
  assign hit_wfi    = (instr_rdata_i == dbg_mon_pkg::WFI_ENC);
  assign hit_dret   = (instr_rdata_i == dbg_mon_pkg::DRET_ENC);

  // ------------------------------------------------------------
  // Class select
  // ------------------------------------------------------------
  always_comb begin
    instr_class_o = dbg_mon_pkg::INSTR_OTHER;
    if (decode_ok) begin
      if (hit_ebreak) begin
        // Compressed flag is the only thing telling c.ebreak apart
        if (is_compressed_i) begin
          instr_class_o = dbg_mon_pkg::INSTR_CEBREAK;
        end else begin
          instr_class_o = dbg_mon_pkg::INSTR_EBREAK;
        end
      end else if (hit_wfi) begin
        instr_class_o = dbg_mon_pkg::INSTR_WFI;
      end else if (hit_dret) begin
        instr_class_o = dbg_mon_pkg::INSTR_DRET;
      end
    end
  end

endmodule

/* hw/dbg_mon_pkg.sv */
// Debug event monitor package
// Shared widths, instruction encodings and the state, cause and class enums

package dbg_mon_pkg;

  // ------------------------------------------------------------
  // Instruction width and encodings seen in decode
  // ------------------------------------------------------------
  localparam int unsigned INSTR_W = 32;

  // ebreak and c.ebreak both arrive in decode with this word
  localparam logic [INSTR_W-1:0] EBREAK_ENC = 32'h0010_0073;
  localparam logic [INSTR_W-1:0] WFI_ENC    = 32'h1050_0073;
  localparam logic [INSTR_W-1:0] DRET_ENC   = 32'h7B20_0073;

  // ------------------------------------------------------------
  // Core controller FSM states
  // ------------------------------------------------------------
  typedef enum logic [3:0] {
    RESET        = 4'd0,
    BOOT_SET     = 4'd1,
    DECODE       = 4'd2,
    DBG_TAKEN_ID = 4'd3,
    DBG_TAKEN_IF = 4'd4,
    FLUSH_EX     = 4'd5,
    FLUSH_WB     = 4'd6,
    SLEEP        = 4'd7
  } ctrl_state_e;

  // Debug cause, same coding as the dcsr cause field
  typedef enum logic [2:0] {
    DBG_CAUSE_NONE    = 3'd0,
    DBG_CAUSE_EBREAK  = 3'd1,
    DBG_CAUSE_TRIGGER = 3'd2,
    DBG_CAUSE_HALTREQ = 3'd3,
    DBG_CAUSE_STEP    = 3'd4
  } dbg_cause_e;

  // Class of the instruction currently in decode
  typedef enum logic [2:0] {
    INSTR_OTHER   = 3'd0,
    INSTR_EBREAK  = 3'd1,
    INSTR_CEBREAK = 3'd2,
    INSTR_WFI     = 3'd3,
    INSTR_DRET    = 3'd4
  } instr_class_e;

endpackage

/* hw/dbg_monitor_top.sv */
// Debug event monitor top level
// Ties the classifier, cause tracker, PC capture and wfi tracker together

`timescale 1ns/100ps

module dbg_monitor_top #(
  parameter int unsigned PC_W    = 32,
  parameter int unsigned NUM_IRQ = 32
) (
  input  logic                              cov_assert_if,
  input  logic                              rst_n_i,
  // Controller and decode stage
  input  dbg_mon_pkg::ctrl_state_e          ctrl_state_i,
  input  logic                              instr_valid_i,
  input  logic                              is_decoding_i,
  input  logic                              is_compressed_i,
  input  logic [dbg_mon_pkg::INSTR_W-1:0]   instr_rdata_i,
  // Debug inputs
  input  logic                              trigger_match_i,
  input  logic                              debug_req_i,
  input  logic                              dcsr_ebreakm_i,
  input  logic                              dcsr_step_i,
  input  logic                              debug_mode_i,
  // PCs and halt address
  input  logic [PC_W-1:0]                   id_pc_i,
  input  logic [PC_W-1:0]                   if_pc_i,
  input  logic [PC_W-1:0]                   dm_halt_addr_i,
  // Interrupts
  input  logic [NUM_IRQ-1:0]                irq_i,
  input  logic [NUM_IRQ-1:0]                mie_i,
  // Monitor outputs
  output dbg_mon_pkg::instr_class_e         instr_class_o,
  output dbg_mon_pkg::dbg_cause_e           expected_cause_o,
  output logic [PC_W-1:0]                   pc_at_dbg_req_o,
  output logic [PC_W-1:0]                   pc_at_ebreak_o,
  output logic [PC_W-1:0]                   halt_addr_o,
  output logic                              halt_addr_valid_o,
  output logic                              in_wfi_o,
  output logic                              pending_irq_o
);

  // ------------------------------------------------------------
  // Instruction class, shared by every block
  // ------------------------------------------------------------
  dbg_instr_classify u_classify (
    .instr_valid_i   (instr_valid_i),
    .is_decoding_i   (is_decoding_i),
    .is_compressed_i (is_compressed_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_class_o   (instr_class_o)
  );

  dbg_cause_tracker u_cause (
    .cov_assert_if    (cov_assert_if),
    .rst_n_i          (rst_n_i),
    .ctrl_state_i     (ctrl_state_i),
    .instr_class_i    (instr_class_o),
    .trigger_match_i  (trigger_match_i),
    .debug_req_i      (debug_req_i),
    .dcsr_ebreakm_i   (dcsr_ebreakm_i),
    .dcsr_step_i      (dcsr_step_i),
    .is_decoding_i    (is_decoding_i),
    .instr_valid_i    (instr_valid_i),
    .expected_cause_o (expected_cause_o)
  );

  dbg_pc_capture #(
    .PC_W (PC_W)
  ) u_pc_capture (
    .cov_assert_if     (cov_assert_if),
    .rst_n_i           (rst_n_i),
    .ctrl_state_i      (ctrl_state_i),
    .instr_class_i     (instr_class_o),
    .id_pc_i           (id_pc_i),
    .if_pc_i           (if_pc_i),
    .dm_halt_addr_i    (dm_halt_addr_i),
    .debug_mode_i      (debug_mode_i),
    .pc_at_dbg_req_o   (pc_at_dbg_req_o),
    .pc_at_ebreak_o    (pc_at_ebreak_o),
    .halt_addr_o       (halt_addr_o),
    .halt_addr_valid_o (halt_addr_valid_o)
  );

  dbg_wfi_tracker #(
    .NUM_IRQ (NUM_IRQ)
  ) u_wfi (
    .cov_assert_if (cov_assert_if),
    .rst_n_i       (rst_n_i),
    .instr_class_i (instr_class_o),
    .debug_mode_i  (debug_mode_i),
    .dcsr_step_i   (dcsr_step_i),
    .debug_req_i   (debug_req_i),
    .irq_i         (irq_i),
    .mie_i         (mie_i),
    .in_wfi_o      (in_wfi_o),
    .pending_irq_o (pending_irq_o)
  );

endmodule

/* hw/dbg_pc_capture.sv */
// Debug entry PC capture
// Holds the PC at debug request, the PC at ebreak and the halt address

`timescale 1ns/100ps

module dbg_pc_capture #(
  parameter int unsigned PC_W = 32
) (
  input  logic                       cov_assert_if,
  input  logic                       rst_n_i,
  input  dbg_mon_pkg::ctrl_state_e   ctrl_state_i,
  input  dbg_mon_pkg::instr_class_e  instr_class_i,
  input  logic [PC_W-1:0]            id_pc_i,
  input  logic [PC_W-1:0]            if_pc_i,
  input  logic [PC_W-1:0]            dm_halt_addr_i,
  input  logic                       debug_mode_i,
  output logic [PC_W-1:0]            pc_at_dbg_req_o,
  output logic [PC_W-1:0]            pc_at_ebreak_o,
  output logic [PC_W-1:0]            halt_addr_o,
  output logic                       halt_addr_valid_o
);

  logic is_any_ebreak;
  logic dbg_taken;
  logic halt_set;
  logic halt_clr;

  assign is_any_ebreak = (instr_class_i == dbg_mon_pkg::INSTR_EBREAK) ||
                         (instr_class_i == dbg_mon_pkg::INSTR_CEBREAK);

  assign dbg_taken = (ctrl_state_i == dbg_mon_pkg::DBG_TAKEN_ID) ||
                     (ctrl_state_i == dbg_mon_pkg::DBG_TAKEN_IF);

  // First debug-taken state after the flag was cleared
  assign halt_set = !halt_addr_valid_o && dbg_taken;

  // Leaving debug mode, or ebreak inside debug which re-enters at halt addr
  assign halt_clr = (halt_addr_valid_o && !debug_mode_i) ||
                    (debug_mode_i && is_any_ebreak);

  // ------------------------------------------------------------
  // PC captures
  // ------------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      pc_at_dbg_req_o <= '0;
      pc_at_ebreak_o  <= '0;
    end else begin
      if (ctrl_state_i == dbg_mon_pkg::DBG_TAKEN_ID) begin
        pc_at_dbg_req_o <= id_pc_i;
      end else if (ctrl_state_i == dbg_mon_pkg::DBG_TAKEN_IF) begin
        pc_at_dbg_req_o <= if_pc_i;
      end

      if (is_any_ebreak) begin
        pc_at_ebreak_o <= id_pc_i;
      end
    end
  end

  // ------------------------------------------------------------
  // Halt address and its valid flag
  // ------------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      halt_addr_valid_o <= 1'b0;
    end else if (halt_clr) begin
      // Clear takes priority over a set in the same cycle
      halt_addr_valid_o <= 1'b0;
    end else if (halt_set) begin
      halt_addr_valid_o <= 1'b1;
    end
  end

  // Word aligned, as the core jumps there
  always_ff @(posedge cov_assert_if) begin
    if (halt_set) begin
      halt_addr_o <= {dm_halt_addr_i[PC_W-1:2], 2'b00};
    end
  end

endmodule

/* hw/dbg_wfi_tracker.sv */
// Wait-for-interrupt tracker
// Reduces enabled interrupts and follows the core's wfi sleep state

`timescale 1ns/100ps

module dbg_wfi_tracker #(
  parameter int unsigned NUM_IRQ = 32
) (
  input  logic                       cov_assert_if,
  input  logic                       rst_n_i,
  input  dbg_mon_pkg::instr_class_e  instr_class_i,
  input  logic                       debug_mode_i,
  input  logic                       dcsr_step_i,
  input  logic                       debug_req_i,
  input  logic [NUM_IRQ-1:0]         irq_i,
  input  logic [NUM_IRQ-1:0]         mie_i,
  output logic                       in_wfi_o,
  output logic                       pending_irq_o
);

  logic wfi_enter;
  logic wfi_wake;

  // Any interrupt that is both raised and enabled
  assign pending_irq_o = |(irq_i & mie_i);

  // wfi sleeps only outside debug mode and when not single stepping
  assign wfi_enter = (instr_class_i == dbg_mon_pkg::INSTR_WFI) &&
                     !debug_mode_i && !dcsr_step_i;

  assign wfi_wake  = pending_irq_o || debug_req_i;

  // ------------------------------------------------------------
  // Sleep state
  // ------------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      in_wfi_o <= 1'b0;
    end else if (wfi_enter) begin
      in_wfi_o <= 1'b1;
    end else if (wfi_wake) begin
      in_wfi_o <= 1'b0;
    end
  end

endmodule

/* sim/dbg_monitor_assert.sv */
// Debug event monitor assertions
// Bound to the top level, checks output invariants every cycle

`timescale 1ns/100ps

module dbg_monitor_assert #(
  parameter int unsigned PC_W = 32
) (
  input  logic                       cov_assert_if,
  input  logic                       rst_n_i,
  input  dbg_mon_pkg::instr_class_e  instr_class_i,
  input  logic                       debug_req_i,
  input  dbg_mon_pkg::dbg_cause_e    expected_cause_i,
  input  logic [PC_W-1:0]            halt_addr_i,
  input  logic                       halt_addr_valid_i,
  input  logic                       in_wfi_i,
  input  logic                       pending_irq_i,
  input  logic [PC_W-1:0]            pc_at_ebreak_i
);

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  // Cause field never goes past the step code
  cause_in_range: assert property (@(posedge cov_assert_if) disable iff (!rst_n_i)
    expected_cause_i <= dbg_mon_pkg::DBG_CAUSE_STEP)
    else begin
      fail_count++;
      $error("expected cause out of range");
    end

  halt_addr_aligned: assert property (@(posedge cov_assert_if) disable iff (!rst_n_i)
    halt_addr_valid_i |-> (halt_addr_i[1:0] == 2'b00))
    else begin
      fail_count++;
      $error("halt address not word aligned");
    end

  // A wake needs an enabled interrupt or a debug request one cycle earlier
  wfi_wake_cause: assert property (@(posedge cov_assert_if) disable iff (!rst_n_i)
    ($fell(in_wfi_i) && $past(rst_n_i)) |-> $past(pending_irq_i || debug_req_i))
    else begin
      fail_count++;
      $error("in_wfi fell without a wake reason");
    end

  ebreak_pc_update: assert property (@(posedge cov_assert_if) disable iff (!rst_n_i)
    ($changed(pc_at_ebreak_i) && $past(rst_n_i)) |->
      $past((instr_class_i == dbg_mon_pkg::INSTR_EBREAK) ||
            (instr_class_i == dbg_mon_pkg::INSTR_CEBREAK)))
    else begin
      fail_count++;
      $error("ebreak PC changed without an ebreak");
    end

endmodule

/* sim/tb_dbg_monitor.sv */
// Debug event monitor testbench
// Random stimulus against a cycle model of the monitor rules

`timescale 1ns/100ps

module tb_dbg_monitor;

  localparam int PC_W        = 32;
  localparam int NUM_IRQ     = 32;
  localparam int TEST_CYCLES = 2000;
  // Four random tests plus reset with generous margin
  localparam int CYCLE_LIMIT = 6 * TEST_CYCLES;

  logic cov_assert_if;
  logic rst_n_i;
  dbg_mon_pkg::ctrl_state_e ctrl_state_i;
  logic instr_valid_i, is_decoding_i, is_compressed_i;
  logic [dbg_mon_pkg::INSTR_W-1:0] instr_rdata_i;
  logic trigger_match_i, debug_req_i, dcsr_ebreakm_i, dcsr_step_i, debug_mode_i;
  logic [PC_W-1:0] id_pc_i, if_pc_i, dm_halt_addr_i;
  logic [NUM_IRQ-1:0] irq_i, mie_i;
  dbg_mon_pkg::instr_class_e instr_class_o;
  dbg_mon_pkg::dbg_cause_e expected_cause_o;
  logic [PC_W-1:0] pc_at_dbg_req_o, pc_at_ebreak_o, halt_addr_o;
  logic halt_addr_valid_o, in_wfi_o, pending_irq_o;

  // Reference model state
  dbg_mon_pkg::dbg_cause_e m_cause;
  logic [PC_W-1:0] m_dbg_pc, m_ebreak_pc, m_halt_addr;
  logic m_halt_known, m_halt_valid, m_in_wfi;

  int error_count = 0;
  int test_errors = 0;
  int check_count = 0;
  int cycle_count = 0;

  dbg_monitor_top #(.PC_W(PC_W), .NUM_IRQ(NUM_IRQ)) uut (.*);

  bind dbg_monitor_top dbg_monitor_assert #(.PC_W(PC_W)) u_assert (
    .cov_assert_if     (cov_assert_if),
    .rst_n_i           (rst_n_i),
    .instr_class_i     (instr_class_o),
    .debug_req_i       (debug_req_i),
    .expected_cause_i  (expected_cause_o),
    .halt_addr_i       (halt_addr_o),
    .halt_addr_valid_i (halt_addr_valid_o),
    .in_wfi_i          (in_wfi_o),
    .pending_irq_i     (pending_irq_o),
    .pc_at_ebreak_i    (pc_at_ebreak_o)
  );

  initial begin
    cov_assert_if = 1'b0;
    forever #50 cov_assert_if = ~cov_assert_if;
  end

  always @(posedge cov_assert_if) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Run timed out after %0d cycles without finishing the tests", cycle_count);
      $display("test failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic dbg_mon_pkg::instr_class_e expected_class();
    dbg_mon_pkg::instr_class_e cls;
    cls = dbg_mon_pkg::INSTR_OTHER;
    if (instr_valid_i && is_decoding_i) begin
      if (instr_rdata_i == dbg_mon_pkg::EBREAK_ENC)
        cls = is_compressed_i ? dbg_mon_pkg::INSTR_CEBREAK : dbg_mon_pkg::INSTR_EBREAK;
      else if (instr_rdata_i == dbg_mon_pkg::WFI_ENC)
        cls = dbg_mon_pkg::INSTR_WFI;
      else if (instr_rdata_i == dbg_mon_pkg::DRET_ENC)
        cls = dbg_mon_pkg::INSTR_DRET;
    end
    return cls;
  endfunction

  task automatic update_model();
    dbg_mon_pkg::instr_class_e cls;
    logic any_ebreak, taken, set_v, clr_v;
    cls = expected_class();
    any_ebreak = (cls == dbg_mon_pkg::INSTR_EBREAK) || (cls == dbg_mon_pkg::INSTR_CEBREAK);
    taken = (ctrl_state_i == dbg_mon_pkg::DBG_TAKEN_ID) ||
            (ctrl_state_i == dbg_mon_pkg::DBG_TAKEN_IF);
    if (!rst_n_i) begin
      m_cause = dbg_mon_pkg::DBG_CAUSE_NONE;
      m_dbg_pc = '0;
      m_ebreak_pc = '0;
      m_halt_valid = 1'b0;
      m_in_wfi = 1'b0;
    end else begin
      if (ctrl_state_i == dbg_mon_pkg::DECODE && is_decoding_i && instr_valid_i) begin
        if (trigger_match_i) m_cause = dbg_mon_pkg::DBG_CAUSE_TRIGGER;
        else if (dcsr_ebreakm_i && any_ebreak) m_cause = dbg_mon_pkg::DBG_CAUSE_EBREAK;
        else if (debug_req_i) m_cause = dbg_mon_pkg::DBG_CAUSE_HALTREQ;
        else if (dcsr_step_i) m_cause = dbg_mon_pkg::DBG_CAUSE_STEP;
        else m_cause = dbg_mon_pkg::DBG_CAUSE_NONE;
      end else if (ctrl_state_i == dbg_mon_pkg::DBG_TAKEN_IF) begin
        if (debug_req_i) m_cause = dbg_mon_pkg::DBG_CAUSE_HALTREQ;
        else if (dcsr_step_i) m_cause = dbg_mon_pkg::DBG_CAUSE_STEP;
      end
      if (ctrl_state_i == dbg_mon_pkg::DBG_TAKEN_ID) m_dbg_pc = id_pc_i;
      else if (ctrl_state_i == dbg_mon_pkg::DBG_TAKEN_IF) m_dbg_pc = if_pc_i;
      if (any_ebreak) m_ebreak_pc = id_pc_i;
      set_v = !m_halt_valid && taken;
      clr_v = (m_halt_valid && !debug_mode_i) || (debug_mode_i && any_ebreak);
      if (set_v) begin
        m_halt_addr = {dm_halt_addr_i[PC_W-1:2], 2'b00};
        m_halt_known = 1'b1;
      end
      if (clr_v) m_halt_valid = 1'b0;
      else if (set_v) m_halt_valid = 1'b1;
      if (cls == dbg_mon_pkg::INSTR_WFI && !debug_mode_i && !dcsr_step_i) m_in_wfi = 1'b1;
      else if ((|(irq_i & mie_i)) || debug_req_i) m_in_wfi = 1'b0;
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus and checks
  // ------------------------------------------------------------
  function automatic logic [31:0] pick_instr();
    case ($urandom % 8)
      0, 1: return dbg_mon_pkg::EBREAK_ENC;
      2: return dbg_mon_pkg::WFI_ENC;
      3: return dbg_mon_pkg::DRET_ENC;
      // One bit off the ebreak word
      4: return dbg_mon_pkg::EBREAK_ENC ^ (32'h1 << ($urandom % 32));
      default: return $urandom;
    endcase
  endfunction

  task automatic drive_inputs(input int mode);
    instr_rdata_i = pick_instr();
    instr_valid_i = ($urandom % 4) != 0;
    is_decoding_i = ($urandom % 4) != 0;
    is_compressed_i = ($urandom % 2) == 1;
    trigger_match_i = ($urandom % 6) == 0;
    debug_req_i = ($urandom % 5) == 0;
    dcsr_ebreakm_i = ($urandom % 2) == 1;
    dcsr_step_i = ($urandom % 4) == 0;
    // Debug mode changes slowly so the halt flag can stay set
    if (($urandom % 8) == 0) debug_mode_i = !debug_mode_i;
    id_pc_i = $urandom;
    if_pc_i = $urandom;
    dm_halt_addr_i = $urandom;
    irq_i = (($urandom % 3) == 0) ? (32'h1 << ($urandom % NUM_IRQ)) : '0;
    mie_i = $urandom;
    case (mode)
      3: ctrl_state_i = (($urandom % 2) == 1) ? dbg_mon_pkg::DECODE : dbg_mon_pkg::DBG_TAKEN_IF;
      4: ctrl_state_i = dbg_mon_pkg::ctrl_state_e'((($urandom % 2) == 1) ? 3 + $urandom % 2
                                                                          : $urandom % 8);
      5: begin
        ctrl_state_i = dbg_mon_pkg::DECODE;
        debug_req_i = ($urandom % 12) == 0;
        irq_i = (($urandom % 8) == 0) ? (32'h1 << ($urandom % NUM_IRQ)) : '0;
      end
      default: ctrl_state_i = dbg_mon_pkg::ctrl_state_e'($urandom % 8);
    endcase
  endtask

  task automatic report_error(input string sig, input logic [31:0] got, input logic [31:0] exp);
    error_count++;
    test_errors++;
    $display("** Error at %0t ns: %s is %h, expected %h", $time, sig, got, exp);
  endtask

  task automatic check_outputs();
    check_count++;
    if (instr_class_o !== expected_class())
      report_error("instr_class_o", instr_class_o, expected_class());
    if (expected_cause_o !== m_cause) report_error("expected_cause_o", expected_cause_o, m_cause);
    if (pc_at_dbg_req_o !== m_dbg_pc) report_error("pc_at_dbg_req_o", pc_at_dbg_req_o, m_dbg_pc);
    if (pc_at_ebreak_o !== m_ebreak_pc)
      report_error("pc_at_ebreak_o", pc_at_ebreak_o, m_ebreak_pc);
    if (m_halt_known && halt_addr_o !== m_halt_addr)
      report_error("halt_addr_o", halt_addr_o, m_halt_addr);
    if (halt_addr_valid_o !== m_halt_valid)
      report_error("halt_addr_valid_o", halt_addr_valid_o, m_halt_valid);
    if (in_wfi_o !== m_in_wfi) report_error("in_wfi_o", in_wfi_o, m_in_wfi);
    if (pending_irq_o !== (|(irq_i & mie_i)))
      report_error("pending_irq_o", pending_irq_o, |(irq_i & mie_i));
  endtask

  // Model steps on the edge, inputs move 10 ns later, outputs checked mid-cycle
  task automatic run_test(input int num, input string name);
    test_errors = 0;
    repeat (TEST_CYCLES) begin
      @(posedge cov_assert_if);
      update_model();
      #10 drive_inputs(num);
      #40 check_outputs();
    end
    $display("Test %0d (%s) finished with %0d errors", num, name, test_errors);
  endtask

  initial begin
    rst_n_i = 1'b0;
    ctrl_state_i = dbg_mon_pkg::RESET;
    {instr_valid_i, is_decoding_i, is_compressed_i} = '0;
    instr_rdata_i = '0;
    {trigger_match_i, debug_req_i, dcsr_ebreakm_i, dcsr_step_i, debug_mode_i} = '0;
    {id_pc_i, if_pc_i, dm_halt_addr_i} = '0;
    irq_i = '0;
    mie_i = '0;
    m_halt_known = 1'b0;
    void'($urandom(32'hddd68e07));

    repeat (2) begin
      @(posedge cov_assert_if);
      update_model();
    end
    #10 rst_n_i = 1'b1;
    #40;
    test_errors = 0;
    check_outputs();
    if (expected_cause_o !== dbg_mon_pkg::DBG_CAUSE_NONE)
      report_error("expected_cause_o", expected_cause_o, dbg_mon_pkg::DBG_CAUSE_NONE);
    if (halt_addr_valid_o !== 1'b0) report_error("halt_addr_valid_o", halt_addr_valid_o, 0);
    if (in_wfi_o !== 1'b0) report_error("in_wfi_o", in_wfi_o, 0);
    if (pc_at_dbg_req_o !== '0) report_error("pc_at_dbg_req_o", pc_at_dbg_req_o, 0);
    if (pc_at_ebreak_o !== '0) report_error("pc_at_ebreak_o", pc_at_ebreak_o, 0);
    $display("Test 1 (reset values) finished with %0d errors", test_errors);

    run_test(2, "classification");
    run_test(3, "cause priority");
    run_test(4, "capture");
    run_test(5, "wfi");

    $display("Cycle checks: %0d, errors: %0d, assertion failures: %0d",
             check_count, error_count, uut.u_assert.fail_count);
    if (error_count == 0 && uut.u_assert.fail_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

/* src.f */
hw/dbg_mon_pkg.sv
hw/dbg_instr_classify.sv
hw/dbg_cause_tracker.sv
hw/dbg_pc_capture.sv
hw/dbg_wfi_tracker.sv
hw/dbg_monitor_top.sv
sim/dbg_monitor_assert.sv
sim/tb_dbg_monitor.sv
